//--- hl_ctrl.f
+incdir+verilog
verilog/hl_cmd_pkg.sv
verilog/hl_radio_pkg.sv
verilog/ds_frame_parser.sv
verilog/ctrl_regs.sv
verilog/tx_guard.sv
verilog/resp_serializer.sv
verilog/hl_ctrl_top.sv
testbench/tb_hl_ctrl_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the command path testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f hl_ctrl.f --top-module tb_hl_ctrl_top \
  -Mdir obj_dir -o sim_hl_ctrl > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_hl_ctrl > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -qx "All tests passed" sim.log && exit 0 || exit 1

//--- testbench/tb_hl_ctrl_top.sv
//////////////////////////////
// testbench for the command path top level
// sends frames, keeps a model of settings, tx_en
// and replies, and checks the DUT against it
//////////////////////////////

`timescale 1ns/10ps
`include "hl_params.svh"

module tb_hl_ctrl_top;

  localparam int WDOG_EARLY  = (`HL_WDOG_MSEC - 1) * `HL_TICKS_PER_MSEC;
  localparam int WDOG_LATE   = `HL_WDOG_MSEC * `HL_TICKS_PER_MSEC;
  localparam int MAX_FRAMES  = 40;
  // eight strobes, each after up to three idle cycles, plus one idle
  localparam int FRAME_MAX   = 8 * 4 + 1;
  localparam int TIMEOUT_CYC = MAX_FRAMES * FRAME_MAX + 3 * WDOG_LATE + 200;

  logic                      clk_ctrl;
  logic                      rst_n_i;
  logic                      eth_valid_i;
  logic [7:0]                eth_data_i;
  logic                      tx_inhibit_i;
  hl_radio_pkg::radio_cfg_t  cfg_o;
  logic                      tx_en_o;
  logic                      resp_valid_o;
  logic [7:0]                resp_byte_o;

  int                        seed;
  bit                        gaps_on;
  logic                      frame_c4;
  hl_cmd_pkg::cmd_t          frame_cmd;

  // reference model state
  logic [1:0]                stb_pipe;
  logic [1:0]                inh_pipe;
  hl_cmd_pkg::cmd_t          pend_cmd;
  hl_radio_pkg::radio_cfg_t  exp_cfg;
  logic                      exp_mox;
  logic                      tx_m;
  logic                      tx_known;
  logic                      hdr_known;
  int                        since_stb;
  int                        resp_cnt;
  logic [7:0]                exp_resp [5];
  int                        mism_cnt;
  int                        other_cnt;

  hl_ctrl_top u_dut (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n_i),
    .eth_valid_i  (eth_valid_i),
    .eth_data_i   (eth_data_i),
    .tx_inhibit_i (tx_inhibit_i),
    .cfg_o        (cfg_o),
    .tx_en_o      (tx_en_o),
    .resp_valid_o (resp_valid_o),
    .resp_byte_o  (resp_byte_o)
  );

  always #10 clk_ctrl = ~clk_ctrl;

  //////////////////////////////
  // model, stepped on the same edges as the DUT
  always @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stb_pipe  <= '0;
      inh_pipe  <= '0;
      pend_cmd  <= '0;
      exp_cfg   <= '0;
      exp_mox   <= 1'b0;
      tx_m      <= 1'b0;
      tx_known  <= 1'b1;
      hdr_known <= 1'b1;
      since_stb <= 0;
      resp_cnt  <= 0;
    end else begin
      // C4 taken at this edge, command strobe two edges later
      stb_pipe <= {stb_pipe[0], eth_valid_i & frame_c4};
      inh_pipe <= {inh_pipe[0], tx_inhibit_i};
      if (eth_valid_i && frame_c4) begin
        pend_cmd <= frame_cmd;
      end
      // trip state is only certain outside the watchdog window
      tx_m     <= exp_mox && !inh_pipe[1] && (since_stb < WDOG_LATE);
      tx_known <= !exp_mox || inh_pipe[1] || (since_stb <= WDOG_EARLY) ||
                  (since_stb >= WDOG_LATE);
      if (stb_pipe[1]) begin
        since_stb <= 0;
        exp_mox   <= pend_cmd.mox;
        if (pend_cmd.addr == `HL_ADDR_GENERAL) begin
          exp_cfg.rate      <= pend_cmd.data[25:24];
          exp_cfg.num_rx_m1 <= pend_cmd.data[6:3];
        end else if (pend_cmd.addr == `HL_ADDR_TX) begin
          exp_cfg.drive_level <= pend_cmd.data[31:24];
          exp_cfg.pa_en       <= pend_cmd.data[19];
        end
      end else if (since_stb < 2 * WDOG_LATE) begin
        since_stb <= since_stb + 1;
      end
      if (stb_pipe[1] && pend_cmd.resp_rqst) begin
        exp_resp[0] <= {pend_cmd.addr, tx_m, inh_pipe[1]};
        exp_resp[1] <= pend_cmd.data[31:24];
        exp_resp[2] <= pend_cmd.data[23:16];
        exp_resp[3] <= pend_cmd.data[15:8];
        exp_resp[4] <= pend_cmd.data[7:0];
        hdr_known   <= tx_known;
        resp_cnt    <= 5;
      end else if (resp_cnt != 0) begin
        resp_cnt <= resp_cnt - 1;
      end
    end
  end

  //////////////////////////////
  // checks, sampled mid-cycle
  always @(negedge clk_ctrl) begin : check_outputs
    int          idx;
    logic [7:0]  mask;
    if (rst_n_i) begin
      assert (cfg_o == exp_cfg) else begin
        mism_cnt = mism_cnt + 1;
        $display("Mismatch cfg_o: expected %h, got %h", exp_cfg, cfg_o);
      end
      assert (!tx_known || tx_en_o == tx_m) else begin
        mism_cnt = mism_cnt + 1;
        $display("Mismatch tx_en_o: expected %h, got %h", tx_m, tx_en_o);
      end
      assert (resp_valid_o == (resp_cnt != 0)) else begin
        mism_cnt = mism_cnt + 1;
        $display("Mismatch resp_valid_o: expected %h, got %h", resp_cnt != 0, resp_valid_o);
      end
      if (resp_cnt == 0) begin
        assert (resp_byte_o == 8'h00) else begin
          mism_cnt = mism_cnt + 1;
          $display("Mismatch resp_byte_o: expected 00, got %h", resp_byte_o);
        end
      end else begin
        idx  = 5 - resp_cnt;
        // header tx_en bit is skipped while the trip time is uncertain
        mask = (idx == 0 && !hdr_known) ? 8'hFD : 8'hFF;
        assert ((resp_byte_o & mask) == (exp_resp[idx] & mask)) else begin
          mism_cnt = mism_cnt + 1;
          $display("Mismatch resp_byte_o: expected %h, got %h", exp_resp[idx], resp_byte_o);
        end
      end
    end
  end

  a_tx_needs_mox : assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    tx_en_o |-> $past(exp_mox))
    else begin
      other_cnt = other_cnt + 1;
      $display("tx_en_o was high while no MOX request was in force");
    end

  a_resp_len : assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    $fell(resp_valid_o) |-> $past(resp_valid_o, 5) && !$past(resp_valid_o, 6))
    else begin
      other_cnt = other_cnt + 1;
      $display("a reply burst was not exactly five cycles long");
    end

  function automatic hl_cmd_pkg::cmd_t make_cmd(input logic [5:0] addr, input logic mox,
                                                input logic rqst);
    hl_cmd_pkg::cmd_t c;
    c.resp_rqst = rqst;
    c.addr      = addr;
    c.mox       = mox;
    c.data      = $random(seed);
    return c;
  endfunction

  task automatic drive_byte(input logic [7:0] b, input logic last);
    int gap;
    gap = gaps_on ? int'($unsigned($random(seed)) % 4) : 0;
    repeat (gap) begin
      @(posedge clk_ctrl);
      eth_valid_i <= 1'b0;
      frame_c4    <= 1'b0;
    end
    @(posedge clk_ctrl);
    eth_valid_i <= 1'b1;
    eth_data_i  <= b;
    frame_c4    <= last;
  endtask

  // broken_pos below zero gives a good frame
  task automatic send_frame(input hl_cmd_pkg::cmd_t c, input int broken_pos);
    logic [39:0] w;
    logic [7:0]  b;
    w = c;
    frame_cmd <= c;
    for (int i = 0; i < `HL_SYNC_COUNT; i++) begin
      drive_byte((i == broken_pos) ? 8'h3C : `HL_SYNC_BYTE, 1'b0);
    end
    for (int k = 0; k < 5; k++) begin
      b = w[39 - 8 * k -: 8];
      // broken payload must not form a new sync run
      if (broken_pos >= 0 && b == `HL_SYNC_BYTE) begin
        b = 8'h7E;
      end
      drive_byte(b, (broken_pos < 0) && (k == 4));
    end
    @(posedge clk_ctrl);
    eth_valid_i <= 1'b0;
    frame_c4    <= 1'b0;
  endtask

  initial begin
    clk_ctrl     = 1'b0;
    rst_n_i      = 1'b0;
    eth_valid_i  = 1'b0;
    eth_data_i   = 8'h00;
    tx_inhibit_i = 1'b0;
    frame_c4     = 1'b0;
    frame_cmd    = '0;
    gaps_on      = 1'b0;
    seed         = 32'h843b;
    mism_cnt     = 0;
    other_cnt    = 0;
    repeat (4) @(posedge clk_ctrl);
    rst_n_i <= 1'b1;
    @(posedge clk_ctrl);

    // general and tx registers, then undecoded addresses
    for (int n = 0; n < 6; n++) begin
      send_frame(make_cmd(`HL_ADDR_GENERAL, 1'b0, 1'b0), -1);
    end
    send_frame(make_cmd(`HL_ADDR_TX, 1'b0, 1'b0), -1);
    send_frame(make_cmd(6'h01, 1'b0, 1'b0), -1);
    send_frame(make_cmd(`HL_ADDR_TX, 1'b0, 1'b0), -1);
    send_frame(make_cmd(6'h12, 1'b0, 1'b0), -1);
    send_frame(make_cmd(6'h3F, 1'b0, 1'b1), -1);

    // broken sync runs with random gaps, each followed by a good frame
    gaps_on = 1'b1;
    for (int p = 0; p < `HL_SYNC_COUNT; p++) begin
      send_frame(make_cmd(`HL_ADDR_TX, 1'b1, 1'b1), p);
      send_frame(make_cmd((p % 2 == 0) ? `HL_ADDR_GENERAL : `HL_ADDR_TX, 1'b0, 1'b1), -1);
    end

    // replies with and without a request
    send_frame(make_cmd(`HL_ADDR_GENERAL, 1'b0, 1'b1), -1);
    send_frame(make_cmd(`HL_ADDR_TX, 1'b0, 1'b0), -1);

    // MOX, then inhibit held while commands keep coming
    send_frame(make_cmd(`HL_ADDR_TX, 1'b1, 1'b1), -1);
    send_frame(make_cmd(`HL_ADDR_GENERAL, 1'b1, 1'b0), -1);
    @(posedge clk_ctrl);
    tx_inhibit_i <= 1'b1;
    for (int n = 0; n < 3; n++) begin
      send_frame(make_cmd(`HL_ADDR_TX, 1'b1, 1'b1), -1);
    end
    tx_inhibit_i <= 1'b0;
    for (int n = 0; n < 3; n++) begin
      send_frame(make_cmd(`HL_ADDR_GENERAL, 1'b1, 1'b1), -1);
    end

    // commands stop, watchdog drops transmit, a new command clears it
    send_frame(make_cmd(`HL_ADDR_TX, 1'b1, 1'b0), -1);
    repeat (WDOG_LATE + 20) @(posedge clk_ctrl);
    send_frame(make_cmd(`HL_ADDR_TX, 1'b1, 1'b1), -1);
    send_frame(make_cmd(`HL_ADDR_GENERAL, 1'b0, 1'b1), -1);
    repeat (10) @(posedge clk_ctrl);

    $display("checks done: %0d mismatches, %0d other errors", mism_cnt, other_cnt);
    if (mism_cnt + other_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYC * 20);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- verilog/hl_ctrl_top.sv
//////////////////////////////
// command path top: parser, control registers,
// transmit guard and response serializer
//////////////////////////////

`timescale 1ns/10ps

module hl_ctrl_top (
  input  logic                      clk_ctrl,
  input  logic                      rst_n_i,
  input  logic                      eth_valid_i,
  input  logic [7:0]                eth_data_i,
  input  logic                      tx_inhibit_i,
  output hl_radio_pkg::radio_cfg_t  cfg_o,
  output logic                      tx_en_o,
  output logic                      resp_valid_o,
  output logic [7:0]                resp_byte_o
);

  hl_cmd_pkg::cmd_t          cmd;
  logic                      cmd_stb;
  logic                      mox_req;
  hl_radio_pkg::tx_status_t  tx_status;

  //////////////////////////////
  // input side
  ds_frame_parser u_parser (
    .clk_ctrl    (clk_ctrl),
    .rst_n_i     (rst_n_i),
    .eth_valid_i (eth_valid_i),
    .eth_data_i  (eth_data_i),
    .cmd_o       (cmd),
    .cmd_stb_o   (cmd_stb)
  );

  //////////////////////////////
  // processing
  ctrl_regs u_regs (
    .clk_ctrl  (clk_ctrl),
    .rst_n_i   (rst_n_i),
    .cmd_i     (cmd),
    .cmd_stb_i (cmd_stb),
    .cfg_o     (cfg_o),
    .mox_req_o (mox_req)
  );

  tx_guard u_guard (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n_i),
    .mox_req_i    (mox_req),
    .cmd_stb_i    (cmd_stb),
    .tx_inhibit_i (tx_inhibit_i),
    .status_o     (tx_status)
  );

  assign tx_en_o = tx_status.tx_en;

  //////////////////////////////
  // output side
  resp_serializer u_resp (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n_i),
    .cmd_i        (cmd),
    .cmd_stb_i    (cmd_stb),
    .status_i     (tx_status),
    .resp_valid_o (resp_valid_o),
    .resp_byte_o  (resp_byte_o)
  );

endmodule

//--- verilog/resp_serializer.sv
//////////////////////////////
// response serializer: on a command asking for a
// reply, sends the header byte then C1..C4
//////////////////////////////

`timescale 1ns/10ps
`include "hl_params.svh"

module resp_serializer (
  input  logic                      clk_ctrl,
  input  logic                      rst_n_i,
  input  hl_cmd_pkg::cmd_t          cmd_i,
  input  logic                      cmd_stb_i,
  input  hl_radio_pkg::tx_status_t  status_i,
  output logic                      resp_valid_o,
  output logic [7:0]                resp_byte_o
);

  localparam int CNT_W = $clog2(`HL_RESP_BYTES);

  hl_radio_pkg::resp_hdr_t  hdr;
  logic [31:0]              data_sr;
  logic [CNT_W-1:0]         byte_cnt;
  logic                     start;

  assign start = cmd_stb_i & cmd_i.resp_rqst;

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= 1'b0;
      byte_cnt     <= '0;
    end else if (start) begin
      resp_valid_o <= 1'b1;
      byte_cnt     <= '0;
    end else if (resp_valid_o) begin
      byte_cnt <= byte_cnt + 1'b1;
      if (byte_cnt == CNT_W'(`HL_RESP_BYTES - 1)) begin
        resp_valid_o <= 1'b0;
      end
    end
  end

  // header and data, tx state as held at the strobe
  always_ff @(posedge clk_ctrl) begin
    if (start) begin
      hdr     <= '{addr: cmd_i.addr, tx_en: status_i.tx_en, inhibit: status_i.inhibit};
      data_sr <= cmd_i.data;
    end else if (resp_valid_o && byte_cnt != '0) begin
      data_sr <= {data_sr[23:0], 8'h00};
    end
  end

  always_comb begin
    if (!resp_valid_o) begin
      resp_byte_o = 8'h00;
    end else if (byte_cnt == '0) begin
      resp_byte_o = hdr;
    end else begin
      resp_byte_o = data_sr[31:24];
    end
  end

  // frame spacing keeps a second request out of a running reply
  a_no_overlap : assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    start |-> !resp_valid_o);

endmodule

//--- verilog/tx_guard.sv
//////////////////////////////
// transmit guard that syncs the inhibit pin, makes the
// millisecond tick and drops transmit when commands
// stop arriving
//////////////////////////////

`timescale 1ns/10ps
`include "hl_params.svh"

module tx_guard (
  input  logic                      clk_ctrl,
  input  logic                      rst_n_i,
  input  logic                      mox_req_i,
  input  logic                      cmd_stb_i,
  input  logic                      tx_inhibit_i,
  output hl_radio_pkg::tx_status_t  status_o
);

  localparam int TICK_W = $clog2(`HL_TICKS_PER_MSEC);
  localparam int MSEC_W = $clog2(`HL_WDOG_MSEC + 1);

  logic               inh_meta;
  logic               inh_sync;
  logic [TICK_W-1:0]  tick_cnt;
  logic               msec_tick;
  logic [MSEC_W-1:0]  msec_cnt;
  logic               wdog_trip;
  logic               tx_en;

  assign msec_tick = (tick_cnt == TICK_W'(`HL_TICKS_PER_MSEC - 1));

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      inh_meta  <= 1'b0;
      inh_sync  <= 1'b0;
      tick_cnt  <= '0;
      msec_cnt  <= '0;
      wdog_trip <= 1'b0;
      tx_en     <= 1'b0;
    end else begin
      // async pin through two flops
      inh_meta <= tx_inhibit_i;
      inh_sync <= inh_meta;

      // free running divider
      tick_cnt <= msec_tick ? '0 : tick_cnt + 1'b1;

      if (cmd_stb_i) begin
        msec_cnt  <= '0;
        wdog_trip <= 1'b0;
      end else if (msec_tick && !wdog_trip) begin
        if (msec_cnt == MSEC_W'(`HL_WDOG_MSEC - 1)) begin
          wdog_trip <= 1'b1;
        end else begin
          msec_cnt <= msec_cnt + 1'b1;
        end
      end

      tx_en <= mox_req_i & ~inh_sync & ~wdog_trip;
    end
  end

  assign status_o = '{tx_en: tx_en, inhibit: inh_sync, wdog_trip: wdog_trip};

  // pin high three edges back keeps transmit off
  a_inhibit_wins : assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    tx_en |-> !$past(tx_inhibit_i, 3));

endmodule

//--- verilog/ctrl_regs.sv
//////////////////////////////
// control registers that decode commands into the
// radio settings and hold the MOX request
//////////////////////////////

`timescale 1ns/10ps
`include "hl_params.svh"

module ctrl_regs (
  input  logic                      clk_ctrl,
  input  logic                      rst_n_i,
  input  hl_cmd_pkg::cmd_t          cmd_i,
  input  logic                      cmd_stb_i,
  output hl_radio_pkg::radio_cfg_t  cfg_o,
  output logic                      mox_req_o
);

  hl_cmd_pkg::cmd_word_u word;

  assign word = cmd_i.data;

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_o     <= '0;
      mox_req_o <= 1'b0;
    end else if (cmd_stb_i) begin
      // every command carries MOX
      mox_req_o <= cmd_i.mox;
      case (cmd_i.addr)
        `HL_ADDR_GENERAL: begin
          cfg_o.rate      <= word.general.rate;
          cfg_o.num_rx_m1 <= word.general.num_rx_m1;
        end
        `HL_ADDR_TX: begin
          cfg_o.drive_level <= word.tx.drive_level;
          cfg_o.pa_en       <= word.tx.pa_en;
        end
        default: begin
          // other registers live elsewhere
        end
      endcase
    end
  end

  // settings move only right after a command strobe
  a_cfg_on_stb : assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    $changed(cfg_o) |-> $past(cmd_stb_i));

endmodule

//--- verilog/ds_frame_parser.sv
//////////////////////////////
// downstream frame parser: hunts for the sync run,
// then collects C0..C4 into one command and pulses
// cmd_stb_o one cycle after C4 is taken
//////////////////////////////

`timescale 1ns/10ps
`include "hl_params.svh"

module ds_frame_parser (
  input  logic                clk_ctrl,
  input  logic                rst_n_i,
  input  logic                eth_valid_i,
  input  logic [7:0]          eth_data_i,
  output hl_cmd_pkg::cmd_t    cmd_o,
  output logic                cmd_stb_o
);

  localparam int CMD_W  = $bits(hl_cmd_pkg::cmd_t);
  localparam int SYNC_W = $clog2(`HL_SYNC_COUNT);
  localparam int IDX_W  = $clog2(`HL_CMD_BYTES);

  typedef enum logic {ST_HUNT, ST_CMD} state_t;

  state_t             state;
  logic [SYNC_W-1:0]  sync_cnt;
  logic [IDX_W-1:0]   byte_idx;
  logic               c4_seen;
  logic [CMD_W-1:0]   cmd_sr;

  //////////////////////////////
  // sync hunt and byte index
  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state     <= ST_HUNT;
      sync_cnt  <= '0;
      byte_idx  <= '0;
      c4_seen   <= 1'b0;
      cmd_stb_o <= 1'b0;
    end else begin
      c4_seen   <= 1'b0;
      cmd_stb_o <= c4_seen;
      if (eth_valid_i) begin
        case (state)
          ST_HUNT: begin
            if (eth_data_i == `HL_SYNC_BYTE) begin
              if (sync_cnt == SYNC_W'(`HL_SYNC_COUNT - 1)) begin
                state    <= ST_CMD;
                sync_cnt <= '0;
                byte_idx <= '0;
              end else begin
                sync_cnt <= sync_cnt + 1'b1;
              end
            end else begin
              // broken run, start over
              sync_cnt <= '0;
            end
          end
          ST_CMD: begin
            byte_idx <= byte_idx + 1'b1;
            if (byte_idx == IDX_W'(`HL_CMD_BYTES - 1)) begin
              c4_seen <= 1'b1;
              state   <= ST_HUNT;
            end
          end
          default: state <= ST_HUNT;
        endcase
      end
    end
  end

  // C0 ends up in the top byte after five shifts
  always_ff @(posedge clk_ctrl) begin
    if (eth_valid_i && state == ST_CMD) begin
      cmd_sr <= {cmd_sr[CMD_W-9:0], eth_data_i};
    end
  end

  // holds until the next frame's C0, well after the strobe
  assign cmd_o = hl_cmd_pkg::cmd_t'(cmd_sr);

  // a frame is at least eight strobes long
  a_stb_single : assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    cmd_stb_o |=> !cmd_stb_o);

endmodule

//--- verilog/hl_radio_pkg.sv
//////////////////////////////
// radio side types: current settings, transmit
// status and the first byte of a response
//////////////////////////////

package hl_radio_pkg;

  typedef struct packed {
    logic [1:0] rate;
    logic [3:0] num_rx_m1;
    logic [7:0] drive_level;
    logic       pa_en;
  } radio_cfg_t;

  typedef struct packed {
    logic tx_en;
    // inhibit after the 2-flop synchronizer
    logic inhibit;
    logic wdog_trip;
  } tx_status_t;

  // response byte 0
  typedef struct packed {
    logic [5:0] addr;
    logic       tx_en;
    logic       inhibit;
  } resp_hdr_t;

endpackage

//--- verilog/hl_cmd_pkg.sv
//////////////////////////////
// command types for the downstream control path
// one command as parsed from C0..C4, plus the two
// register views of its 32-bit data word
//////////////////////////////

package hl_cmd_pkg;

  // C0 in the top byte, then C1..C4 in data
  typedef struct packed {
    logic        resp_rqst;
    logic [5:0]  addr;
    logic        mox;
    logic [31:0] data;
  } cmd_t;

  // address 0x00: sample rate and receiver count
  typedef struct packed {
    logic [5:0]  rsvd_c1;
    logic [1:0]  rate;
    logic [15:0] rsvd_c2_c3;
    logic        rsvd_c4_hi;
    logic [3:0]  num_rx_m1;
    logic [2:0]  rsvd_c4_lo;
  } general_word_t;

  // address 0x09: drive level and PA enable
  typedef struct packed {
    logic [7:0]  drive_level;
    logic [3:0]  rsvd_c2_hi;
    logic        pa_en;
    logic [2:0]  rsvd_c2_lo;
    logic [15:0] rsvd_c3_c4;
  } tx_word_t;

  typedef union packed {
    general_word_t general;
    tx_word_t      tx;
  } cmd_word_u;

endpackage

//--- verilog/hl_params.svh
//////////////////////////////
// constants for the command path: frame format,
// register addresses and watchdog timing
// include where a module needs them
//////////////////////////////

`ifndef HL_PARAMS_SVH
`define HL_PARAMS_SVH

// frame format
`define HL_SYNC_BYTE      8'h7F
`define HL_SYNC_COUNT     3
`define HL_CMD_BYTES      5
`define HL_RESP_BYTES     5

// register addresses decoded in the control block
`define HL_ADDR_GENERAL   6'h00
`define HL_ADDR_TX        6'h09

// clk_ctrl cycles per millisecond tick
`define HL_TICKS_PER_MSEC 2500
// ticks with no command before transmit is dropped
`define HL_WDOG_MSEC      4

`endif
